/* core_pkg.sv */
package core_pkg;

	localparam int DATA_W  = 32;
	localparam int REG_AW  = 5;
	localparam int SHAMT_W = 5;
	localparam int IMM_W   = 16;

	////////////////////////////////////////////////////////////
	// instruction encodings

	localparam logic [5:0] OPCODE_SPECIAL = 6'b000000;
	localparam logic [5:0] OPCODE_ADDIU   = 6'b001001;
	localparam logic [5:0] OPCODE_SLTI    = 6'b001010;
	localparam logic [5:0] OPCODE_SLTIU   = 6'b001011;
	localparam logic [5:0] OPCODE_ANDI    = 6'b001100;
	localparam logic [5:0] OPCODE_ORI     = 6'b001101;
	localparam logic [5:0] OPCODE_XORI    = 6'b001110;
	localparam logic [5:0] OPCODE_LUI     = 6'b001111;

	localparam logic [5:0] FUNCT_SLL  = 6'b000000;
	localparam logic [5:0] FUNCT_SRL  = 6'b000010;
	localparam logic [5:0] FUNCT_SRA  = 6'b000011;
	localparam logic [5:0] FUNCT_SLLV = 6'b000100;
	localparam logic [5:0] FUNCT_SRLV = 6'b000110;
	localparam logic [5:0] FUNCT_SRAV = 6'b000111;
	localparam logic [5:0] FUNCT_ADDU = 6'b100001;
	localparam logic [5:0] FUNCT_SUBU = 6'b100011;
	localparam logic [5:0] FUNCT_AND  = 6'b100100;
	localparam logic [5:0] FUNCT_OR   = 6'b100101;
	localparam logic [5:0] FUNCT_XOR  = 6'b100110;
	localparam logic [5:0] FUNCT_NOR  = 6'b100111;
	localparam logic [5:0] FUNCT_SLT  = 6'b101010;
	localparam logic [5:0] FUNCT_SLTU = 6'b101011;

	////////////////////////////////////////////////////////////
	// control types and stage payloads

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	typedef enum logic {SRC_A_REG, SRC_A_SHAMT} src_a_t;
	typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_t;

	typedef struct packed {
		logic [DATA_W-1:0]  pc;
		logic [REG_AW-1:0]  rs_num;
		logic [REG_AW-1:0]  rt_num;
		logic [DATA_W-1:0]  rs_val;
		logic [DATA_W-1:0]  rt_val;
		logic [DATA_W-1:0]  imm;
		logic [SHAMT_W-1:0] shamt;
		alu_op_t            alu_op;
		src_a_t             src_a;
		src_b_t             src_b;
		logic [REG_AW-1:0]  dest;
		logic               writes;
	} decoded_t;

	typedef struct packed {
		logic [DATA_W-1:0] pc;
		logic [REG_AW-1:0] dest;
		logic              writes;
		logic [DATA_W-1:0] value;
	} retire_t;

endpackage

/* bypass_if.sv */
`timescale 1ns/100ps

interface bypass_if import core_pkg::*; ();

	// write sitting in the E/W register
	logic              ex_valid;
	logic [REG_AW-1:0] ex_dest;
	logic [DATA_W-1:0] ex_value;

	// write committed on the previous edge
	logic              wb_valid;
	logic [REG_AW-1:0] wb_dest;
	logic [DATA_W-1:0] wb_value;

	modport ew_side (
		output ex_valid, ex_dest, ex_value
	);

	modport wb_side (
		output wb_valid, wb_dest, wb_value
	);

	modport use_side (
		input ex_valid, ex_dest, ex_value,
		input wb_valid, wb_dest, wb_value
	);

endinterface

/* pipe_stage.sv */
`timescale 1ns/100ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_allowin,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_allowin,
	output payload_t out_data
);

	// take a new entry when empty or when the entry moves on
	assign in_allowin = !rst && (!out_valid || out_allowin);

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_allowin)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_allowin)
			out_data <= in_data;
	end

	a_empty_after_rst: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("stage holds an entry right after reset");

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [REG_AW-1:0] raddr1,
	input  logic [REG_AW-1:0] raddr2,
	input  logic [REG_AW-1:0] waddr,
	input  logic              wen,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata1,
	output logic [DATA_W-1:0] rdata2
);

	logic [DATA_W-1:0] regs [2**REG_AW];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end
		else if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// r0 is hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* decode.sv */
`timescale 1ns/100ps

module decode import core_pkg::*; (
	input  logic [DATA_W-1:0] in_pc,
	input  logic [DATA_W-1:0] in_instr,
	output logic [REG_AW-1:0] rs_num,
	output logic [REG_AW-1:0] rt_num,
	input  logic [DATA_W-1:0] rs_val,
	input  logic [DATA_W-1:0] rt_val,
	output decoded_t          dec
);

	logic [5:0]         op;
	logic [5:0]         funct;
	logic [REG_AW-1:0]  rs;
	logic [REG_AW-1:0]  rt;
	logic [REG_AW-1:0]  rd;
	logic [SHAMT_W-1:0] sa;
	logic [IMM_W-1:0]   imm16;
	logic               zero_ext;

	assign op    = in_instr[31:26];
	assign rs    = in_instr[25:21];
	assign rt    = in_instr[20:16];
	assign rd    = in_instr[15:11];
	assign sa    = in_instr[10:6];
	assign funct = in_instr[5:0];
	assign imm16 = in_instr[IMM_W-1:0];

	assign rs_num = rs;
	assign rt_num = rt;

	// logical immediates are unsigned
	assign zero_ext = op inside {OPCODE_ANDI, OPCODE_ORI, OPCODE_XORI};

	always_comb
	begin
		dec.pc     = in_pc;
		dec.rs_num = rs;
		dec.rt_num = rt;
		dec.rs_val = rs_val;
		dec.rt_val = rt_val;
		dec.imm    = zero_ext ? {{(DATA_W-IMM_W){1'b0}}, imm16}
			: {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
		dec.shamt  = sa;
		dec.alu_op = ALU_ADD;
		dec.src_a  = SRC_A_REG;
		dec.src_b  = SRC_B_REG;
		dec.dest   = rd;
		dec.writes = 1'b1;
		if (op == OPCODE_SPECIAL)
		begin
			case (funct)
				FUNCT_ADDU: dec.alu_op = ALU_ADD;
				FUNCT_SUBU: dec.alu_op = ALU_SUB;
				FUNCT_SLT:  dec.alu_op = ALU_SLT;
				FUNCT_SLTU: dec.alu_op = ALU_SLTU;
				FUNCT_AND:  dec.alu_op = ALU_AND;
				FUNCT_OR:   dec.alu_op = ALU_OR;
				FUNCT_XOR:  dec.alu_op = ALU_XOR;
				FUNCT_NOR:  dec.alu_op = ALU_NOR;
				FUNCT_SLL, FUNCT_SRL, FUNCT_SRA:
				begin
					// shift by sa with the rs field zero
					dec.alu_op = (funct == FUNCT_SLL) ? ALU_SLL
						: (funct == FUNCT_SRL) ? ALU_SRL : ALU_SRA;
					dec.src_a  = SRC_A_SHAMT;
					dec.writes = (rs == '0);
				end
				FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV:
				begin
					dec.alu_op = (funct == FUNCT_SLLV) ? ALU_SLL
						: (funct == FUNCT_SRLV) ? ALU_SRL : ALU_SRA;
					dec.writes = (sa == '0);
				end
				default: dec.writes = 1'b0;
			endcase
		end
		else
		begin
			dec.dest  = rt;
			dec.src_b = SRC_B_IMM;
			case (op)
				OPCODE_ADDIU: dec.alu_op = ALU_ADD;
				OPCODE_SLTI:  dec.alu_op = ALU_SLT;
				OPCODE_SLTIU: dec.alu_op = ALU_SLTU;
				OPCODE_ANDI:  dec.alu_op = ALU_AND;
				OPCODE_ORI:   dec.alu_op = ALU_OR;
				OPCODE_XORI:  dec.alu_op = ALU_XOR;
				OPCODE_LUI:   dec.alu_op = ALU_LUI;
				default:      dec.writes = 1'b0;
			endcase
		end
	end

endmodule

/* execute.sv */
`timescale 1ns/100ps

module execute import core_pkg::*; (
	input  decoded_t         dec,
	bypass_if.use_side       byp,
	output retire_t          ret
);

	logic [DATA_W-1:0] rs_fwd;
	logic [DATA_W-1:0] rt_fwd;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] alu_y;
	logic [SHAMT_W-1:0] sh;

	function automatic logic hit(
		input logic              valid,
		input logic [REG_AW-1:0] dest,
		input logic [REG_AW-1:0] num
	);
		return valid && (dest != '0) && (dest == num);
	endfunction

	////////////////////////////////////////////////////////////
	// operand bypass with the newest write first

	assign rs_fwd = hit(byp.ex_valid, byp.ex_dest, dec.rs_num) ? byp.ex_value
		: hit(byp.wb_valid, byp.wb_dest, dec.rs_num) ? byp.wb_value
		: dec.rs_val;

	assign rt_fwd = hit(byp.ex_valid, byp.ex_dest, dec.rt_num) ? byp.ex_value
		: hit(byp.wb_valid, byp.wb_dest, dec.rt_num) ? byp.wb_value
		: dec.rt_val;

	assign op_a = (dec.src_a == SRC_A_SHAMT) ? {{(DATA_W-SHAMT_W){1'b0}}, dec.shamt}
		: rs_fwd;
	assign op_b = (dec.src_b == SRC_B_IMM) ? dec.imm : rt_fwd;

	// only the low bits of a variable amount count
	assign sh = op_a[SHAMT_W-1:0];

	////////////////////////////////////////////////////////////
	// alu

	always_comb
	begin
		case (dec.alu_op)
			ALU_ADD:  alu_y = op_a + op_b;
			ALU_SUB:  alu_y = op_a - op_b;
			ALU_SLT:  alu_y = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_y = {{(DATA_W-1){1'b0}}, op_a < op_b};
			ALU_AND:  alu_y = op_a & op_b;
			ALU_OR:   alu_y = op_a | op_b;
			ALU_XOR:  alu_y = op_a ^ op_b;
			ALU_NOR:  alu_y = ~(op_a | op_b);
			ALU_SLL:  alu_y = op_b << sh;
			ALU_SRL:  alu_y = op_b >> sh;
			ALU_SRA:  alu_y = $signed(op_b) >>> sh;
			ALU_LUI:  alu_y = {op_b[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};
			default:  alu_y = '0;
		endcase
	end

	assign ret.pc     = dec.pc;
	assign ret.dest   = dec.dest;
	assign ret.writes = dec.writes;
	assign ret.value  = alu_y;

	// decode and the D/E register must hand over a legal operation
	always_comb
	begin
		if (dec.writes)
			a_alu_op_known: assert final (dec.alu_op inside {[ALU_ADD:ALU_LUI]})
				else $error("writing instruction with unknown alu op %0d", dec.alu_op);
	end

endmodule

/* result.sv */
`timescale 1ns/100ps

module result import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              ret_valid,
	input  retire_t           ret,
	input  logic [REG_AW-1:0] rs_num,
	input  logic [REG_AW-1:0] rt_num,
	output logic [DATA_W-1:0] rs_val,
	output logic [DATA_W-1:0] rt_val,
	bypass_if.ew_side         byp_ew,
	bypass_if.wb_side         byp_wb,
	output logic              wb_valid,
	output logic              wb_wen,
	output logic [DATA_W-1:0] wb_pc,
	output logic [DATA_W-1:0] wb_wdata,
	output logic [REG_AW-1:0] wb_wnum
);

	logic              commit;
	logic [DATA_W-1:0] rf_rdata1;
	logic [DATA_W-1:0] rf_rdata2;

	// register 0 is never written
	assign commit = ret_valid && ret.writes && (ret.dest != '0);

	reg_file reg_file_i (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (rs_num),
		.raddr2 (rt_num),
		.waddr  (ret.dest),
		.wen    (commit),
		.wdata  (ret.value),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2)
	);

	// write-through for a read in the same cycle as the write
	assign rs_val = (commit && ret.dest == rs_num) ? ret.value : rf_rdata1;
	assign rt_val = (commit && ret.dest == rt_num) ? ret.value : rf_rdata2;

	assign byp_ew.ex_valid = ret_valid && ret.writes;
	assign byp_ew.ex_dest  = ret.dest;
	assign byp_ew.ex_value = ret.value;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_valid <= 1'b0;
			wb_wen   <= 1'b0;
		end
		else
		begin
			wb_valid <= ret_valid;
			wb_wen   <= commit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ret_valid)
		begin
			wb_pc    <= ret.pc;
			wb_wnum  <= ret.dest;
			wb_wdata <= ret.value;
		end
	end

	// last committed write doubles as the wb bypass entry
	assign byp_wb.wb_valid = wb_wen;
	assign byp_wb.wb_dest  = wb_wnum;
	assign byp_wb.wb_value = wb_wdata;

	a_no_r0_write: assert property (@(posedge clk) disable iff (rst) wb_wen |-> wb_wnum != '0)
		else $error("trace reports a write to register 0");

endmodule

/* mips_core.sv */
`timescale 1ns/100ps

module mips_core import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [DATA_W-1:0] in_pc,
	input  logic [DATA_W-1:0] in_instr,
	output logic              wb_valid,
	output logic [DATA_W-1:0] wb_pc,
	output logic              wb_wen,
	output logic [REG_AW-1:0] wb_wnum,
	output logic [DATA_W-1:0] wb_wdata
);

	logic [REG_AW-1:0] rs_num;
	logic [REG_AW-1:0] rt_num;
	logic [DATA_W-1:0] rs_val;
	logic [DATA_W-1:0] rt_val;
	decoded_t          dec_d;
	decoded_t          dec_e;
	logic              de_valid;
	logic              ew_allowin;
	retire_t           ret_e;
	retire_t           ret_w;
	logic              ew_valid;

	bypass_if byp ();

	////////////////////////////////////////////////////////////
	// decode, D/E, execute, E/W, writeback

	decode decode_i (
		.in_pc    (in_pc),
		.in_instr (in_instr),
		.rs_num   (rs_num),
		.rt_num   (rt_num),
		.rs_val   (rs_val),
		.rt_val   (rt_val),
		.dec      (dec_d)
	);

	pipe_stage #(.payload_t(decoded_t)) de_stage (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_allowin  (in_ready),
		.in_data     (dec_d),
		.out_valid   (de_valid),
		.out_allowin (ew_allowin),
		.out_data    (dec_e)
	);

	execute execute_i (
		.dec (dec_e),
		.byp (byp.use_side),
		.ret (ret_e)
	);

	// nothing downstream of E/W can stall
	pipe_stage #(.payload_t(retire_t)) ew_stage (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (de_valid),
		.in_allowin  (ew_allowin),
		.in_data     (ret_e),
		.out_valid   (ew_valid),
		.out_allowin (1'b1),
		.out_data    (ret_w)
	);

	result result_i (
		.clk       (clk),
		.rst       (rst),
		.ret_valid (ew_valid),
		.ret       (ret_w),
		.rs_num    (rs_num),
		.rt_num    (rt_num),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.byp_ew    (byp.ew_side),
		.byp_wb    (byp.wb_side),
		.wb_valid  (wb_valid),
		.wb_wen    (wb_wen),
		.wb_pc     (wb_pc),
		.wb_wdata  (wb_wdata),
		.wb_wnum   (wb_wnum)
	);

endmodule

/* tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core import core_pkg::*; ();

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	logic [DATA_W-1:0] in_pc;
	logic [DATA_W-1:0] in_instr;
	logic              wb_valid;
	logic [DATA_W-1:0] wb_pc;
	logic              wb_wen;
	logic [REG_AW-1:0] wb_wnum;
	logic [DATA_W-1:0] wb_wdata;

	// stimulus table with expected trace
	string             t_name  [$];
	logic [DATA_W-1:0] t_instr [$];
	logic [DATA_W-1:0] t_pc    [$];
	bit                t_gap   [$];
	bit                t_wen   [$];
	logic [REG_AW-1:0] t_wnum  [$];
	logic [DATA_W-1:0] t_wdata [$];

	// table index and retire cycle of each entry in flight
	int pend_idx [$];
	int pend_due [$];

	logic [DATA_W-1:0] model_regs [32];
	logic [31:0]       rng;
	int                cycle = 0;
	int                limit = 0;
	int                passed = 0;
	int                failed = 0;
	int                errors = 0;

	mips_core mips_core_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_pc    (in_pc),
		.in_instr (in_instr),
		.wb_valid (wb_valid),
		.wb_pc    (wb_pc),
		.wb_wen   (wb_wen),
		.wb_wnum  (wb_wnum),
		.wb_wdata (wb_wdata)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
		return {OPCODE_SPECIAL, rs, rt, rd, sa, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	////////////////////////////////////////////////////////////
	// reference model run as entries are added

	task automatic add_entry(input string name, input logic [31:0] instr, input bit gap);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] v;
		logic [4:0]  sa;
		logic [4:0]  dest;
		bit          ok;
		a    = model_regs[instr[25:21]];
		b    = model_regs[instr[20:16]];
		sa   = instr[10:6];
		sx   = {{16{instr[15]}}, instr[15:0]};
		zx   = {16'h0000, instr[15:0]};
		v    = '0;
		ok   = 1'b1;
		dest = instr[20:16];
		if (instr[31:26] == OPCODE_SPECIAL)
		begin
			dest = instr[15:11];
			case (instr[5:0])
				FUNCT_ADDU: v = a + b;
				FUNCT_SUBU: v = a - b;
				FUNCT_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FUNCT_SLTU: v = (a < b) ? 32'd1 : 32'd0;
				FUNCT_AND:  v = a & b;
				FUNCT_OR:   v = a | b;
				FUNCT_XOR:  v = a ^ b;
				FUNCT_NOR:  v = ~(a | b);
				FUNCT_SLL:  v = b << sa;
				FUNCT_SRL:  v = b >> sa;
				FUNCT_SRA:  v = $signed(b) >>> sa;
				FUNCT_SLLV: v = b << a[4:0];
				FUNCT_SRLV: v = b >> a[4:0];
				FUNCT_SRAV: v = $signed(b) >>> a[4:0];
				default:    ok = 1'b0;
			endcase
			// reserved fields of the shifts
			if (instr[5:0] inside {FUNCT_SLL, FUNCT_SRL, FUNCT_SRA})
				ok = ok && (instr[25:21] == 5'd0);
			if (instr[5:0] inside {FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV})
				ok = ok && (sa == 5'd0);
		end
		else
		begin
			case (instr[31:26])
				OPCODE_ADDIU: v = a + sx;
				OPCODE_SLTI:  v = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
				OPCODE_SLTIU: v = (a < sx) ? 32'd1 : 32'd0;
				OPCODE_ANDI:  v = a & zx;
				OPCODE_ORI:   v = a | zx;
				OPCODE_XORI:  v = a ^ zx;
				OPCODE_LUI:   v = {instr[15:0], 16'h0000};
				default:      ok = 1'b0;
			endcase
		end
		if (ok && dest != 5'd0)
			model_regs[dest] = v;
		t_pc.push_back(32'h0040_0000 + 4 * t_pc.size());
		t_name.push_back(name);
		t_instr.push_back(instr);
		t_gap.push_back(gap);
		t_wen.push_back(ok && dest != 5'd0);
		t_wnum.push_back(dest);
		t_wdata.push_back(v);
	endtask

	task automatic build_table();
		logic [5:0]  functs [14];
		string       names [14];
		logic [31:0] k;
		logic [4:0]  rs;
		logic [4:0]  sa;
		functs = '{FUNCT_ADDU, FUNCT_SUBU, FUNCT_SLT, FUNCT_SLTU, FUNCT_AND, FUNCT_OR,
			FUNCT_XOR, FUNCT_NOR, FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_SLLV,
			FUNCT_SRLV, FUNCT_SRAV};
		names = '{"addu", "subu", "slt", "sltu", "and", "or", "xor", "nor",
			"sll", "srl", "sra", "sllv", "srlv", "srav"};
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		// random constants in r1..r8 with the odd ones negative
		for (int r = 1; r <= 8; r++)
		begin
			k = next_rand();
			if (r % 2 == 1)
				k[15] = 1'b1;
			add_entry($sformatf("lui_r%0d", r), enc_i(OPCODE_LUI, 5'(r), 5'd0, k[15:0]), 1'b0);
			add_entry($sformatf("ori_r%0d", r), enc_i(OPCODE_ORI, 5'(r), 5'(r), k[31:16]),
				1'b0);
		end
		for (int i = 0; i < 14; i++)
		begin
			k  = next_rand();
			rs = 5'(1 + k[2:0]);
			sa = k[10:6];
			if (functs[i] inside {FUNCT_SLL, FUNCT_SRL, FUNCT_SRA})
				rs = 5'd0;
			else
				sa = 5'd0;
			add_entry(names[i], enc_r(functs[i], 5'(9 + i), rs, 5'(1 + k[5:3]), sa), i % 3 == 2);
		end
		add_entry("addiu_neg", enc_i(OPCODE_ADDIU, 5'd23, 5'd1, 16'hfff0), 1'b0);
		add_entry("slti_neg", enc_i(OPCODE_SLTI, 5'd24, 5'd3, 16'h8001), 1'b1);
		add_entry("sltiu_high", enc_i(OPCODE_SLTIU, 5'd25, 5'd2, 16'h8000), 1'b0);
		add_entry("andi_high", enc_i(OPCODE_ANDI, 5'd23, 5'd3, 16'hf0f0), 1'b0);
		add_entry("ori_high", enc_i(OPCODE_ORI, 5'd24, 5'd5, 16'h8421), 1'b1);
		add_entry("xori_high", enc_i(OPCODE_XORI, 5'd25, 5'd7, 16'hffff), 1'b0);
		add_entry("lui_high", enc_i(OPCODE_LUI, 5'd26, 5'd0, 16'h8765), 1'b0);
		// dependent chain at distances 1 to 3
		add_entry("dep_base", enc_i(OPCODE_ADDIU, 5'd27, 5'd0, 16'h0123), 1'b0);
		add_entry("dep_dist1", enc_r(FUNCT_ADDU, 5'd28, 5'd27, 5'd1, 5'd0), 1'b0);
		add_entry("dep_dist2", enc_r(FUNCT_XOR, 5'd29, 5'd2, 5'd27, 5'd0), 1'b0);
		add_entry("dep_dist3", enc_r(FUNCT_SUBU, 5'd30, 5'd27, 5'd3, 5'd0), 1'b0);
		add_entry("dep_self", enc_i(OPCODE_ADDIU, 5'd30, 5'd30, 16'h0001), 1'b0);
		add_entry("dep_both", enc_r(FUNCT_OR, 5'd31, 5'd30, 5'd29, 5'd0), 1'b0);
		// register 0 and unknown encodings
		add_entry("write_r0", enc_r(FUNCT_ADDU, 5'd0, 5'd1, 5'd2, 5'd0), 1'b0);
		add_entry("read_r0", enc_r(FUNCT_OR, 5'd9, 5'd0, 5'd0, 5'd0), 1'b0);
		add_entry("addiu_r0", enc_i(OPCODE_ADDIU, 5'd0, 5'd1, 16'h0005), 1'b1);
		add_entry("unknown_op", 32'h8c22_0004, 1'b0);
		add_entry("unknown_funct", enc_r(6'b100000, 5'd10, 5'd1, 5'd2, 5'd0), 1'b0);
		add_entry("sll_bad_rs", enc_r(FUNCT_SLL, 5'd11, 5'd3, 5'd4, 5'd2), 1'b1);
		add_entry("srav_bad_sa", enc_r(FUNCT_SRAV, 5'd12, 5'd3, 5'd4, 5'd1), 1'b0);
		add_entry("read_kept", enc_r(FUNCT_ADDU, 5'd13, 5'd10, 5'd11, 5'd0), 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			k = next_rand();
			add_entry($sformatf("gap_mix_%0d", i),
				enc_i(OPCODE_ADDIU, 5'(1 + k[2:0]), 5'(1 + k[5:3]), k[31:16]), k[8]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// checks

	task automatic report_test(input string name, input bit bad);
		if (bad)
		begin
			failed++;
			$display("FAIL %s", name);
		end
		else
		begin
			passed++;
			$display("PASS %s", name);
		end
	endtask

	task automatic check_retire(input int i);
		bit bad;
		bad = 1'b0;
		assert (wb_valid === 1'b1) else
		begin
			$display("%s did not retire 2 cycles after acceptance", t_name[i]);
			bad = 1'b1;
		end
		if (wb_valid === 1'b1)
		begin
			assert (wb_pc === t_pc[i]) else
			begin
				$display("ERR %s wb_pc expected %h actual %h", t_name[i], t_pc[i], wb_pc);
				bad = 1'b1;
			end
			assert (wb_wen === t_wen[i]) else
			begin
				$display("ERR %s wb_wen expected %b actual %b", t_name[i], t_wen[i], wb_wen);
				bad = 1'b1;
			end
			if (t_wen[i])
			begin
				assert (wb_wnum === t_wnum[i]) else
				begin
					$display("ERR %s wb_wnum expected %0d actual %0d", t_name[i], t_wnum[i],
						wb_wnum);
					bad = 1'b1;
				end
				assert (wb_wdata === t_wdata[i]) else
				begin
					$display("ERR %s wb_wdata expected %h actual %h", t_name[i], t_wdata[i],
						wb_wdata);
					bad = 1'b1;
				end
			end
		end
		report_test(t_name[i], bad);
	endtask

	always @(negedge clk)
	begin
		if (rst === 1'b0)
		begin
			if (in_valid)
			begin
				assert (in_ready === 1'b1) else
				begin
					$display("in_ready low while an instruction was offered, cycle %0d", cycle);
					errors++;
				end
			end
			if (pend_due.size() > 0 && pend_due[0] == cycle)
			begin
				check_retire(pend_idx.pop_front());
				void'(pend_due.pop_front());
			end
			else
			begin
				assert (wb_valid !== 1'b1) else
				begin
					$display("unexpected retire of pc %h at cycle %0d", wb_pc, cycle);
					errors++;
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (limit > 0 && cycle > limit)
		begin
			$display("timeout after %0d cycles, %0d instructions not retired", cycle,
				pend_idx.size());
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		int tbl_cycles;
		bit bad;
		clk = 1'b0;
		rst      <= 1'b1;
		in_valid <= 1'b0;
		in_pc    <= '0;
		in_instr <= '0;
		rng = 32'd35246;
		build_table();
		tbl_cycles = t_instr.size();
		foreach (t_gap[i])
			if (t_gap[i])
				tbl_cycles++;
		limit = tbl_cycles + 2 + 4 + 20;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		bad = 1'b0;
		assert (wb_valid === 1'b0 && wb_wen === 1'b0 && in_ready === 1'b1) else
		begin
			$display("after reset the trace is active or in_ready is low");
			bad = 1'b1;
		end
		report_test("reset", bad);

		for (int i = 0; i < t_instr.size(); i++)
		begin
			if (t_gap[i])
			begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(posedge clk);
			in_valid <= 1'b1;
			in_pc    <= t_pc[i];
			in_instr <= t_instr[i];
			// accepted on the next edge and traced two edges later
			pend_idx.push_back(i);
			pend_due.push_back(cycle + 4);
		end
		@(posedge clk);
		in_valid <= 1'b0;

		while (pend_idx.size() > 0)
			@(posedge clk);
		repeat (3) @(negedge clk);
		@(posedge clk);
		$display("%0d tests, %0d passed, %0d failed, %0d other errors",
			passed + failed, passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* mips_core.f */
core_pkg.sv
bypass_if.sv
pipe_stage.sv
reg_file.sv
decode.sv
execute.sv
result.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mips_core
FLIST     = mips_core.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
